/* dv/rtp_engine_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// network side protocol checks, bound into the top level
module rtp_engine_sva
  import rtp_stream_pkg::*;
(
  input wire                  aclk,
  input wire                  aresetn,
  input wire                  m_valid,
  input wire [data_width-1:0] m_data,
  input wire [keep_width-1:0] m_keep,
  input wire                  m_last,
  input wire                  m_ready
);

  // a stalled beat stays put
  a_hold_on_stall: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_keep) && $stable(m_last)))
    else $error("output beat changed while m_ready was low");

  // nothing valid straight out of reset
  a_quiet_after_reset: assert property (@(posedge aclk)
    !aresetn |=> (!m_valid && !m_last))
    else $error("m_valid or m_last high in the cycle after reset");

  // end of packet only on a valid beat
  a_last_needs_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    m_last |-> m_valid)
    else $error("m_last high without m_valid");

endmodule : rtp_engine_sva

bind rtp_engine rtp_engine_sva i_sva (
  .aclk    (aclk),
  .aresetn (aresetn),
  .m_valid (m_valid),
  .m_data  (m_data),
  .m_keep  (m_keep),
  .m_last  (m_last),
  .m_ready (m_ready)
);

`default_nettype wire

/* dv/tb_rtp_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the rtp packetizer
// random lines go in and packets come out with headers checked against a software model
module tb_rtp_engine;

  localparam logic [31:0] ssrc            = 32'h1234abcd;
  localparam int          frame_rate      = 30;
  localparam int          lines_per_frame = 4;
  localparam int          fifo_depth      = 16;
  // 90 khz media clock divided by the frame rate
  localparam logic [31:0] ts_step         = 32'd90000 / frame_rate;
  localparam int          beat_timeout    = 200;

  logic        aclk;
  logic        aresetn;
  logic        s_valid;
  logic [63:0] s_data;
  logic        s_last;
  logic        s_ready;
  logic        m_valid;
  logic [63:0] m_data;
  logic [7:0]  m_keep;
  logic        m_last;
  logic        m_ready;
  logic        dropped_pkt;

  // lfsr state and bookkeeping
  logic [15:0] lfsr;
  int          errors;
  int          checks;
  int          tests_run;
  logic        aborted;
  logic        out_done;

  // current line is built here before it is driven
  logic [63:0] line_data [8];
  int          line_gap [8];
  int          line_len;
  logic [63:0] exp_payload [$];

  // reference model of the header fields
  logic [31:0] mdl_seq;
  logic [15:0] mdl_line;
  logic        mdl_skip;
  logic [31:0] mdl_ts;

  rtp_engine #(
    .SSRC_ID         (ssrc),
    .FRAME_RATE      (frame_rate),
    .LINES_PER_FRAME (lines_per_frame),
    .FIFO_DEPTH      (fifo_depth)
  ) i_dut (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .s_last      (s_last),
    .s_ready     (s_ready),
    .m_valid     (m_valid),
    .m_data      (m_data),
    .m_keep      (m_keep),
    .m_last      (m_last),
    .m_ready     (m_ready),
    .dropped_pkt (dropped_pkt)
  );

  // 20 ns clock
  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ******************************
  // helpers
  // ******************************

  // lfsr x^16 + x^14 + x^13 + x^11 + 1 steps once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("timeout: %s", what);
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    $display("test %0d %s done, %0d errors", tests_run, name, errors - errors_before);
  endtask

  // model step at the end of a packet
  task automatic advance_model();
    int step;
    step     = mdl_skip ? 2 : 1;
    mdl_skip = 1'b0;
    mdl_seq  = mdl_seq + 32'd1;
    if (int'(mdl_line) + step >= lines_per_frame) begin
      // frame wrap starts a new timestamp
      mdl_line = 16'd0;
      mdl_ts   = mdl_ts + ts_step;
    end else begin
      mdl_line = mdl_line + 16'(step);
    end
  endtask

  // expected beat k of the current packet
  task automatic expected_beat(input int k, output logic [63:0] data, output logic [7:0] keep);
    logic mk;
    mk   = (mdl_line == 16'(lines_per_frame - 1));
    keep = 8'hff;
    case (k)
      0: data = {2'd2, 1'b0, 1'b0, 4'd0, mk, 7'd96, mdl_seq[15:0], mdl_ts};
      1: begin
        data = {ssrc, 32'h0};
        keep = 8'hf0;
      end
      // length 3840 with field, continuation and offset all 0
      2: data = {mdl_seq[31:16], 16'd3840, 1'b0, mdl_line[14:0], 16'h0};
      default: begin
        if (exp_payload.size() == 0) begin
          errors++;
          $display("output payload beat arrived with no input beat left");
          data = '0;
        end else begin
          data = exp_payload.pop_front();
        end
      end
    endcase
  endtask

  // ******************************
  // stream drivers and monitor
  // ******************************
  task automatic drive_line();
    int i;
    int g;
    int waited;
    for (i = 0; i < line_len; i++) begin
      // idle gap before the beat
      for (g = 0; g < line_gap[i]; g++) begin
        @(posedge aclk);
        s_valid <= 1'b0;
      end
      @(posedge aclk);
      s_valid <= 1'b1;
      s_data  <= line_data[i];
      s_last  <= (i == line_len - 1);
      exp_payload.push_back(line_data[i]);
      waited = 0;
      while (!aborted) begin
        @(negedge aclk);
        if (s_ready) begin
          break;
        end
        waited++;
        if (waited > beat_timeout) begin
          abort_on_timeout("input beat was never accepted by s_ready");
        end
      end
    end
    @(posedge aclk);
    s_valid <= 1'b0;
    s_last  <= 1'b0;
  endtask

  // random back-pressure with ready about three cycles in four
  task automatic drive_ready();
    int c;
    for (c = 0; c < 20 * beat_timeout && !out_done; c++) begin
      @(posedge aclk);
      m_ready <= (rand_bits(2) != 64'd0);
    end
  endtask

  // beats are sampled mid cycle and accepted at the next rising edge
  task automatic collect_packet();
    int          k;
    int          idle;
    logic [63:0] exp_data;
    logic [7:0]  exp_keep;
    k    = 0;
    idle = 0;
    while (k < line_len + 3 && !aborted) begin
      @(negedge aclk);
      if (m_valid && m_ready) begin
        idle = 0;
        expected_beat(k, exp_data, exp_keep);
        check($sformatf("m_data[%0d]", k), m_data, exp_data);
        check($sformatf("m_keep[%0d]", k), 64'(m_keep), 64'(exp_keep));
        check($sformatf("m_last[%0d]", k), 64'(m_last), 64'(k == line_len + 2));
        k++;
      end else begin
        idle++;
        if (idle > beat_timeout) begin
          abort_on_timeout("output packet did not complete");
        end
      end
    end
    out_done = 1'b1;
  endtask

  // one line in and one packet out followed by an optional loss pulse
  task automatic run_packet(input logic with_drop);
    int i;
    line_len = int'(rand_bits(3)) + 1;
    for (i = 0; i < line_len; i++) begin
      line_data[i] = rand_bits(64);
      line_gap[i]  = int'(rand_bits(2));
    end
    out_done = 1'b0;
    fork
      drive_line();
      collect_packet();
      drive_ready();
    join
    advance_model();
    if (with_drop) begin
      // pulse lands after pkt_done of this packet
      @(posedge aclk);
      dropped_pkt <= 1'b1;
      @(posedge aclk);
      dropped_pkt <= 1'b0;
      mdl_skip = 1'b1;
    end
  endtask

  // ******************************
  // test sequence
  // ******************************
  initial begin
    int   n;
    int   errors_before;
    logic drop;
    aresetn     = 1'b0;
    s_valid     = 1'b0;
    s_data      = '0;
    s_last      = 1'b0;
    m_ready     = 1'b0;
    dropped_pkt = 1'b0;
    lfsr        = 16'd50;
    errors      = 0;
    checks      = 0;
    tests_run   = 0;
    aborted     = 1'b0;
    out_done    = 1'b0;
    mdl_seq     = '0;
    mdl_line    = '0;
    mdl_skip    = 1'b0;
    mdl_ts      = '0;

    // outputs quiet in and right after reset
    errors_before = errors;
    @(posedge aclk);
    @(negedge aclk);
    check("m_valid", 64'(m_valid), 64'd0);
    check("m_last", 64'(m_last), 64'd0);
    check("s_ready", 64'(s_ready), 64'd0);
    @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    check("m_valid", 64'(m_valid), 64'd0);
    check("m_last", 64'(m_last), 64'd0);
    check("s_ready", 64'(s_ready), 64'd0);
    close_test("reset outputs", errors_before);

    // headers, payload and frame wrap without loss
    errors_before = errors;
    for (n = 0; n < 12 && !aborted; n++) begin
      run_packet(1'b0);
    end
    close_test("headers, payload and wrap", errors_before);

    // loss pulses between packets
    errors_before = errors;
    for (n = 0; n < 10 && !aborted; n++) begin
      drop = (rand_bits(1) == 64'd1) || (n == 1);
      run_packet(drop);
    end
    close_test("dropped packet skip", errors_before);

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_rtp_engine

`default_nettype wire

/* hdl/rtp_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// rtp packetizer for uncompressed progressive video, one line per packet
module rtp_engine
  import rtp_stream_pkg::*;
#(
  parameter logic [31:0] SSRC_ID         = 32'h0,
  parameter int          FRAME_RATE      = 30,
  parameter int          LINES_PER_FRAME = 1280,
  parameter int          FIFO_DEPTH      = 512
) (
  input  wire                   aclk,
  input  wire                   aresetn,
  // camera side stream
  input  wire                   s_valid,
  input  wire  [data_width-1:0] s_data,
  input  wire                   s_last,
  output logic                  s_ready,
  // network side stream
  output logic                  m_valid,
  output logic [data_width-1:0] m_data,
  output logic [keep_width-1:0] m_keep,
  output logic                  m_last,
  input  wire                   m_ready,
  // loss indication from downstream
  input  wire                   dropped_pkt
);

  // fifo head towards the packet unit
  logic                  f_valid;
  logic [data_width-1:0] f_data;
  logic                  f_last;
  logic                  f_pop;

  // header field values, stable across one packet
  logic                  pkt_done;
  logic [15:0]           seq_nr;
  logic [15:0]           ext_seq_nr;
  logic [31:0]           timestamp;
  logic [15:0]           line_num;
  logic                  marker;

  rtp_line_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_line_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_data  (s_data),
    .s_last  (s_last),
    .s_ready (s_ready),
    .f_valid (f_valid),
    .f_data  (f_data),
    .f_last  (f_last),
    .f_pop   (f_pop)
  );

  rtp_frame_tracker #(
    .LINES_PER_FRAME (LINES_PER_FRAME),
    .FRAME_RATE      (FRAME_RATE)
  ) i_frame_tracker (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .pkt_done    (pkt_done),
    .dropped_pkt (dropped_pkt),
    .seq_nr      (seq_nr),
    .ext_seq_nr  (ext_seq_nr),
    .timestamp   (timestamp),
    .line_num    (line_num),
    .marker      (marker)
  );

  rtp_packet_fsm #(
    .SSRC_ID (SSRC_ID)
  ) i_packet_fsm (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .f_valid    (f_valid),
    .f_data     (f_data),
    .f_last     (f_last),
    .f_pop      (f_pop),
    .seq_nr     (seq_nr),
    .ext_seq_nr (ext_seq_nr),
    .timestamp  (timestamp),
    .line_num   (line_num),
    .marker     (marker),
    .pkt_done   (pkt_done),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .m_keep     (m_keep),
    .m_last     (m_last),
    .m_ready    (m_ready)
  );

endmodule : rtp_engine

`default_nettype wire

/* hdl/rtp_frame_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

// per packet bookkeeping for the rtp and payload headers
// all values move only on the edge after pkt_done
module rtp_frame_tracker
  import rtp_header_pkg::*;
#(
  parameter int LINES_PER_FRAME = 1280,
  parameter int FRAME_RATE      = 30
) (
  input  wire         aclk,
  input  wire         aresetn,
  input  wire         pkt_done,
  input  wire         dropped_pkt,
  output logic [15:0] seq_nr,
  output logic [15:0] ext_seq_nr,
  output logic [31:0] timestamp,
  output logic [15:0] line_num,
  output logic        marker
);

  // media clock ticks per frame, 3000 at 30 fps
  localparam logic [31:0] ts_step    = rtp_clock_hz / FRAME_RATE;
  localparam logic [16:0] line_limit = 17'(LINES_PER_FRAME);
  localparam logic [15:0] last_line  = 16'(LINES_PER_FRAME - 1);

  logic [31:0] seq_cnt;
  logic        drop_q;
  logic        drop_rise;
  logic        skip_req;
  // one bit wider so a step of two near the top cannot wrap
  logic [16:0] line_step;
  logic        frame_wrap;

  // low half goes in the rtp header, high half in the payload header
  assign seq_nr     = seq_cnt[15:0];
  assign ext_seq_nr = seq_cnt[31:16];

  assign drop_rise  = dropped_pkt && !drop_q;

  assign line_step  = {1'b0, line_num} + (skip_req ? 17'd2 : 17'd1);
  assign frame_wrap = (line_step >= line_limit);

  // last line of the frame carries the marker
  assign marker = (line_num == last_line);

  // ******************************
  // dropped packet skip request
  // ******************************
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      drop_q   <= 1'b0;
      skip_req <= 1'b0;
    end else begin
      drop_q <= dropped_pkt;
      if (pkt_done) begin
        // request is consumed here
        // an edge in the same cycle still counts for the next line
        skip_req <= drop_rise;
      end else if (drop_rise) begin
        skip_req <= 1'b1;
      end
    end
  end

  // ******************************
  // sequence, line and timestamp
  // ******************************
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      seq_cnt   <= '0;
      line_num  <= '0;
      timestamp <= '0;
    end else if (pkt_done) begin
      seq_cnt <= seq_cnt + 32'd1;
      if (frame_wrap) begin
        // new frame, timestamp wraps naturally at 2^32
        line_num  <= '0;
        timestamp <= timestamp + ts_step;
      end else begin
        line_num  <= line_step[15:0];
      end
    end
  end

endmodule : rtp_frame_tracker

`default_nettype wire

/* hdl/rtp_header_pkg.sv */
`default_nettype none

// ******************************
// rtp and rfc 4175 header fields
// ******************************
package rtp_header_pkg;

  // fixed rtp header values, rfc 3550 version with dynamic video type
  localparam logic [1:0]  rtp_version      = 2'd2;
  localparam logic [6:0]  rtp_payload_type = 7'd96;

  // bytes per scan line, 1920 pixels at two bytes each
  localparam logic [15:0] line_length_bytes = 16'd3840;

  // media clock for video timestamps
  localparam logic [31:0] rtp_clock_hz = 32'd90000;

  // byte enables for the header beats
  // the ssrc beat only carries its upper four bytes
  localparam logic [7:0]  hdr_keep_full = 8'hff;
  localparam logic [7:0]  hdr_keep_ssrc = 8'hf0;

  // selects which kind of beat the output mux builds
  typedef enum logic [1:0] {
    beat_rtp_0,
    beat_rtp_1,
    beat_pl_hdr,
    beat_payload
  } hdr_beat_e;

endpackage : rtp_header_pkg

`default_nettype wire

/* hdl/rtp_line_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// line buffer between the camera stream and the packet unit
// keeps each beat together with its end of line flag
module rtp_line_fifo
  import rtp_stream_pkg::*;
#(
  parameter int FIFO_DEPTH = 512
) (
  input  wire                   aclk,
  input  wire                   aresetn,
  input  wire                   s_valid,
  input  wire  [data_width-1:0] s_data,
  input  wire                   s_last,
  output logic                  s_ready,
  output logic                  f_valid,
  output logic [data_width-1:0] f_data,
  output logic                  f_last,
  input  wire                   f_pop
);

  localparam int addr_width = $clog2(FIFO_DEPTH);

  // beat storage with the end of line flag alongside
  logic [data_width-1:0] mem_data [FIFO_DEPTH];
  logic                  mem_last [FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [addr_width:0]   wr_ptr;
  logic [addr_width:0]   rd_ptr;
  logic [addr_width:0]   wr_ptr_nxt;
  logic [addr_width:0]   rd_ptr_nxt;
  logic                  push;
  logic                  pop;
  logic                  full_nxt;

  assign push = s_valid && s_ready;
  assign pop  = f_pop && f_valid;

  assign wr_ptr_nxt = wr_ptr + {{addr_width{1'b0}}, push};
  assign rd_ptr_nxt = rd_ptr + {{addr_width{1'b0}}, pop};

  // full when the addresses meet but the wrap bits differ
  assign full_nxt = (wr_ptr_nxt[addr_width] != rd_ptr_nxt[addr_width]) &&
                    (wr_ptr_nxt[addr_width-1:0] == rd_ptr_nxt[addr_width-1:0]);

  // ******************************
  // pointers and ready
  // ******************************
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      s_ready <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      rd_ptr  <= rd_ptr_nxt;
      // ready follows the fill level after this edge
      s_ready <= !full_nxt;
    end
  end

  // write port
  always_ff @(posedge aclk) begin
    if (push) begin
      mem_data[wr_ptr[addr_width-1:0]] <= s_data;
      mem_last[wr_ptr[addr_width-1:0]] <= s_last;
    end
  end

  // head of queue is shown without a read delay
  // empty when both pointers match including the wrap bit
  assign f_valid = (wr_ptr != rd_ptr);
  assign f_data  = mem_data[rd_ptr[addr_width-1:0]];
  assign f_last  = mem_last[rd_ptr[addr_width-1:0]];

endmodule : rtp_line_fifo

`default_nettype wire

/* hdl/rtp_packet_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

// builds one packet per line
// two rtp header beats, one rfc 4175 payload header beat, then the line data
module rtp_packet_fsm
  import rtp_stream_pkg::*;
  import rtp_header_pkg::*;
#(
  parameter logic [31:0] SSRC_ID = 32'h0
) (
  input  wire                   aclk,
  input  wire                   aresetn,
  input  wire                   f_valid,
  input  wire  [data_width-1:0] f_data,
  input  wire                   f_last,
  output logic                  f_pop,
  input  wire  [15:0]           seq_nr,
  input  wire  [15:0]           ext_seq_nr,
  input  wire  [31:0]           timestamp,
  input  wire  [15:0]           line_num,
  input  wire                   marker,
  output logic                  pkt_done,
  output logic                  m_valid,
  output logic [data_width-1:0] m_data,
  output logic [keep_width-1:0] m_keep,
  output logic                  m_last,
  input  wire                   m_ready
);

  pkt_state_e            st;
  pkt_state_e            st_nxt;
  hdr_beat_e             beat_sel;
  logic                  out_free;
  logic                  last_acc;
  logic                  load;
  logic                  pop;
  logic [data_width-1:0] beat_data;
  logic [keep_width-1:0] beat_keep;
  logic                  beat_last;

  // output register may take a new beat
  assign out_free = !m_valid || m_ready;
  // end of packet seen by the network side
  assign last_acc = m_valid && m_ready && m_last;

  assign pkt_done = last_acc;
  assign f_pop    = pop;

  // ******************************
  // next state and load control
  // ******************************
  always_comb begin
    st_nxt   = st;
    load     = 1'b0;
    pop      = 1'b0;
    beat_sel = beat_payload;
    case (st)
      idle: begin
        beat_sel = beat_rtp_0;
        // start as soon as the line has its first beat
        if (f_valid && out_free) begin
          load   = 1'b1;
          st_nxt = rtp_hdr_0;
        end
      end
      rtp_hdr_0: begin
        beat_sel = beat_rtp_1;
        if (out_free) begin
          load   = 1'b1;
          st_nxt = rtp_hdr_1;
        end
      end
      rtp_hdr_1: begin
        beat_sel = beat_pl_hdr;
        if (out_free) begin
          load   = 1'b1;
          st_nxt = pl_hdr;
        end
      end
      pl_hdr, payload: begin
        if (last_acc) begin
          st_nxt = idle;
        end else if (out_free) begin
          // one fifo pop per loaded beat, empty fifo leaves a gap
          st_nxt = payload;
          if (f_valid) begin
            load = 1'b1;
            pop  = 1'b1;
          end
        end
      end
      default: begin
        st_nxt = idle;
      end
    endcase
  end

  // ******************************
  // beat contents
  // ******************************
  always_comb begin
    beat_keep = hdr_keep_full;
    beat_last = 1'b0;
    case (beat_sel)
      beat_rtp_0: begin
        // v, p, x, cc, m, pt, sequence, timestamp
        beat_data = {rtp_version, 1'b0, 1'b0, 4'h0, marker, rtp_payload_type,
                     seq_nr, timestamp};
      end
      beat_rtp_1: begin
        beat_data = {SSRC_ID, 32'h0};
        beat_keep = hdr_keep_ssrc;
      end
      beat_pl_hdr: begin
        // progressive scan so field is 0, one line so c and offset are 0
        beat_data = {ext_seq_nr, line_length_bytes, 1'b0, line_num[14:0], 1'b0, 15'h0};
      end
      default: begin
        beat_data = f_data;
        beat_last = f_last;
      end
    endcase
  end

  // control part of the output stage
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      st      <= idle;
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else begin
      st <= st_nxt;
      if (out_free) begin
        m_valid <= load;
        m_last  <= load && beat_last;
      end
    end
  end

  // data part, held while the sink stalls
  always_ff @(posedge aclk) begin
    if (load) begin
      m_data <= beat_data;
      m_keep <= beat_keep;
    end
  end

endmodule : rtp_packet_fsm

`default_nettype wire

/* hdl/rtp_stream_pkg.sv */
`default_nettype none

// ******************************
// stream side definitions
// ******************************
package rtp_stream_pkg;

  // width of one beat on both the camera and the network stream
  localparam int data_width = 64;

  // one enable bit per byte of tdata
  localparam int keep_width = data_width / 8;

  // packet unit states
  // each state names the beat that currently sits in the output register
  typedef enum logic [2:0] {
    idle,
    rtp_hdr_0,
    rtp_hdr_1,
    pl_hdr,
    payload
  } pkt_state_e;

endpackage : rtp_stream_pkg

`default_nettype wire

/* project.f */
hdl/rtp_stream_pkg.sv
hdl/rtp_header_pkg.sv
hdl/rtp_line_fifo.sv
hdl/rtp_frame_tracker.sv
hdl/rtp_packet_fsm.sv
hdl/rtp_engine.sv
dv/rtp_engine_sva.sv
dv/tb_rtp_engine.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rtp packetizer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rtp_engine -f project.f -o sim_tb_rtp_engine \
  || { echo "verilator build failed"; exit 1; }

# the run passes only if the pass message shows up in the output
out=$(./obj_dir/sim_tb_rtp_engine 2>&1)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
